//--- Bender.yml
package:
  name: mem_subsys

sources:
  - verilog/mem_pkg.sv
  - verilog/pmp_region.sv
  - verilog/pmp_resolve.sv
  - verilog/pmp_csr_apb.sv
  - verilog/data_ram.sv
  - verilog/mem_arbiter.sv
  - verilog/mem_subsys.sv
  - target: simulation
    files:
      - verif/mem_subsys_tb.sv

//--- mem_subsys.f
verilog/mem_pkg.sv
verilog/pmp_region.sv
verilog/pmp_resolve.sv
verilog/pmp_csr_apb.sv
verilog/data_ram.sv
verilog/mem_arbiter.sv
verilog/mem_subsys.sv
verif/mem_subsys_tb.sv

//--- verif/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

  localparam int NUM_REGIONS  = mem_pkg::default_num_regions;
  localparam int RAM_WORDS    = mem_pkg::default_ram_words;
  localparam int CLOCK_PERIOD = 100;
  localparam int NUM_TESTS    = 20;
  localparam int MAX_WAIT     = 8;     // Cycles allowed for the readies of one access
  localparam int SETUP_CYCLES = 120;   // Reset plus APB writes and readback
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 20 + SETUP_CYCLES;
  localparam mem_pkg::addr_t SIDE_FETCH_ADDR = 32'h0000_0040;

  logic               clock;
  logic               reset;
  logic               imem_valid;
  mem_pkg::addr_t     imem_addr;
  mem_pkg::priv_t     imem_mode;
  logic               imem_ready;
  logic               imem_error;
  mem_pkg::data_t     imem_rdata;
  logic               dmem_valid;
  mem_pkg::addr_t     dmem_addr;
  mem_pkg::priv_t     dmem_mode;
  mem_pkg::data_t     dmem_wdata;
  mem_pkg::strb_t     dmem_wstrb;
  logic               dmem_ready;
  logic               dmem_error;
  mem_pkg::data_t     dmem_rdata;
  logic               psel;
  logic               penable;
  logic               pwrite;
  mem_pkg::apb_addr_t paddr;
  mem_pkg::data_t     pwdata;
  mem_pkg::data_t     prdata;
  logic               pready;
  logic               pslverr;

  // Stimulus table
  string          t_name  [NUM_TESTS];
  logic           t_fetch [NUM_TESTS];
  mem_pkg::priv_t t_mode  [NUM_TESTS];
  mem_pkg::addr_t t_addr  [NUM_TESTS];
  mem_pkg::strb_t t_strb  [NUM_TESTS];
  logic           t_conc  [NUM_TESTS];
  logic           t_err   [NUM_TESTS];
  logic           t_model [NUM_TESTS];
  int             n_tests;

  mem_pkg::addr_t cfg_base   [NUM_REGIONS];
  mem_pkg::addr_t cfg_limit  [NUM_REGIONS];
  mem_pkg::perm_t cfg_perm   [NUM_REGIONS];
  logic           cfg_enable [NUM_REGIONS];

  mem_pkg::data_t model [RAM_WORDS];   // Expected RAM contents
  int             pass_count;
  int             fail_count;

  mem_subsys #(
    .NUM_REGIONS (NUM_REGIONS),
    .RAM_WORDS   (RAM_WORDS)
  ) u_mem_subsys (
    .clock      (clock),
    .reset      (reset),
    .imem_valid (imem_valid),
    .imem_addr  (imem_addr),
    .imem_mode  (imem_mode),
    .imem_ready (imem_ready),
    .imem_error (imem_error),
    .imem_rdata (imem_rdata),
    .dmem_valid (dmem_valid),
    .dmem_addr  (dmem_addr),
    .dmem_mode  (dmem_mode),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .dmem_ready (dmem_ready),
    .dmem_error (dmem_error),
    .dmem_rdata (dmem_rdata),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic add_test(input string name, input logic fetch, input mem_pkg::priv_t mode,
                          input mem_pkg::addr_t addr, input mem_pkg::strb_t strb,
                          input logic conc, input logic err, input logic from_model);
    t_name[n_tests]  = name;
    t_fetch[n_tests] = fetch;
    t_mode[n_tests]  = mode;
    t_addr[n_tests]  = addr;
    t_strb[n_tests]  = strb;
    t_conc[n_tests]  = conc;
    t_err[n_tests]   = err;
    t_model[n_tests] = from_model;
    n_tests++;
  endtask

  function automatic int word_of(input mem_pkg::addr_t addr);
    return int'(addr[31:2] % RAM_WORDS);
  endfunction

  function automatic mem_pkg::data_t merge_bytes(input mem_pkg::data_t old_word,
                                                 input mem_pkg::data_t new_word,
                                                 input mem_pkg::strb_t strb);
    mem_pkg::data_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  // Base, limit, perm, enable at word 0..3 of a region
  function automatic mem_pkg::data_t reg_value(input int r, input int w);
    case (w)
      0:       return cfg_base[r];
      1:       return cfg_limit[r];
      2:       return {29'd0, cfg_perm[r]};
      default: return {31'd0, cfg_enable[r]};
    endcase
  endfunction

  task automatic apb_write(input mem_pkg::apb_addr_t addr, input mem_pkg::data_t data);
    @(negedge clock);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clock);
    penable = 1'b1;
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input mem_pkg::apb_addr_t addr, output mem_pkg::data_t data,
                          output logic err, output logic rdy);
    @(negedge clock);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clock);
    penable = 1'b1;
    @(negedge clock);
    data    = prdata;   // Access phase still held
    err     = pslverr;
    rdy     = pready;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic record_result(input string name, input int errors);
    if (errors == 0) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s", name);
    end
  endtask

  function automatic int check_port(input string name, input string port, input int at,
                                    input int want_at, input logic err, input logic want_err,
                                    input mem_pkg::data_t rdata, input logic check_data,
                                    input mem_pkg::data_t want_data);
    int bad;
    bad = 0;
    if (at == 0) begin
      $display("%s: no ready on the %s port within %0d cycles", name, port, MAX_WAIT);
      bad++;
    end else begin
      if (at != want_at) begin
        $display("Mismatch %s %s latency: expected %0d, actual %0d",
                 name, port, want_at, at);
        bad++;
      end
      if (err !== want_err) begin
        $display("Mismatch %s %s error: expected %b, actual %b", name, port, want_err, err);
        bad++;
      end
      if (check_data && rdata !== want_data) begin
        $display("Mismatch %s %s rdata: expected %h, actual %h",
                 name, port, want_data, rdata);
        bad++;
      end
    end
    return bad;
  endfunction

  task automatic check_apb;
    mem_pkg::data_t got;
    mem_pkg::data_t want;
    logic           err;
    logic           rdy;
    int             bad;
    bad = 0;
    for (int r = 0; r < NUM_REGIONS; r++) begin
      for (int w = 0; w < 4; w++) begin
        want = reg_value(r, w);
        apb_read(8'(16 * r + 4 * w), got, err, rdy);
        if (got !== want || err !== 1'b0) begin
          $display("Mismatch apb_readback %0d.%0d: expected %h/0, actual %h/%b",
                   r, w, want, got, err);
          bad++;
        end
        if (rdy !== 1'b1) begin
          $display("Mismatch apb_readback %0d.%0d pready: expected 1, actual %b",
                   r, w, rdy);
          bad++;
        end
      end
    end
    record_result("apb_readback", bad);
    bad = 0;
    apb_read(8'(16 * NUM_REGIONS), got, err, rdy);   // First offset past the last region
    if (err !== 1'b1) begin
      $display("Mismatch apb_slverr pslverr: expected 1, actual %b", err);
      bad++;
    end
    if (rdy !== 1'b1) begin
      $display("Mismatch apb_slverr pready: expected 1, actual %b", rdy);
      bad++;
    end
    record_result("apb_slverr", bad);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One table entry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_access(input int idx);
    mem_pkg::data_t wdata;
    mem_pkg::data_t d_rdata;
    mem_pkg::data_t i_rdata;
    mem_pkg::data_t want;
    logic           d_err;
    logic           i_err;
    logic           d_exp;
    logic           i_exp;
    logic           check_data;
    int             d_at;
    int             i_at;
    int             lat;
    int             widx;
    int             bad;
    wdata      = $urandom;
    d_exp      = !t_fetch[idx];
    i_exp      = t_fetch[idx] || t_conc[idx];
    d_at       = 0;
    i_at       = 0;
    d_rdata    = '0;
    i_rdata    = '0;
    d_err      = 1'b0;
    i_err      = 1'b0;
    bad        = 0;
    widx       = word_of(t_addr[idx]);
    want       = t_err[idx] ? '0 : model[widx];
    check_data = t_err[idx] || t_model[idx];
    lat        = t_err[idx] ? 1 : 2;   // Fault answers a cycle earlier

    @(negedge clock);
    if (t_fetch[idx]) begin
      imem_valid = 1'b1;
      imem_addr  = t_addr[idx];
      imem_mode  = t_mode[idx];
    end else begin
      dmem_valid = 1'b1;
      dmem_addr  = t_addr[idx];
      dmem_mode  = t_mode[idx];
      dmem_wdata = wdata;
      dmem_wstrb = t_strb[idx];
      if (t_conc[idx]) begin
        imem_valid = 1'b1;
        imem_addr  = SIDE_FETCH_ADDR;
        imem_mode  = mem_pkg::user_mode;
      end
    end

    for (int cyc = 1; cyc <= MAX_WAIT; cyc++) begin
      @(negedge clock);
      if (dmem_ready && d_at == 0) begin
        d_at    = cyc;
        d_rdata = dmem_rdata;
        d_err   = dmem_error;
      end
      if (imem_ready && i_at == 0) begin
        i_at    = cyc;
        i_rdata = imem_rdata;
        i_err   = imem_error;
      end
      imem_valid = 1'b0;   // One-cycle pulses
      dmem_valid = 1'b0;
      if ((d_at != 0 || !d_exp) && (i_at != 0 || !i_exp)) break;
    end

    if (t_fetch[idx]) begin
      bad += check_port(t_name[idx], "fetch", i_at, lat, i_err, t_err[idx], i_rdata,
                        check_data, want);
      if (d_at != 0) begin
        $display("%s: ready on the data port without a data request", t_name[idx]);
        bad++;
      end
    end else begin
      bad += check_port(t_name[idx], "data", d_at, lat, d_err, t_err[idx], d_rdata,
                        check_data, want);
      if (t_conc[idx]) begin
        // Fetch waits for the data access, then takes its own two cycles
        bad += check_port(t_name[idx], "fetch", i_at, lat + 2, i_err, 1'b0, i_rdata, 1'b1,
                          model[word_of(SIDE_FETCH_ADDR)]);
        if (d_at == 0 || i_at == 0 || d_at >= i_at) begin
          $display("%s: data ready did not come before fetch ready", t_name[idx]);
          bad++;
        end
      end else if (i_at != 0) begin
        $display("%s: ready on the fetch port without a fetch request", t_name[idx]);
        bad++;
      end
    end

    if (!t_fetch[idx] && !t_err[idx] && t_strb[idx] != '0) begin
      model[widx] = merge_bytes(model[widx], wdata, t_strb[idx]);
    end
    record_result(t_name[idx], bad);
  endtask

  task automatic build_table;
    n_tests = 0;
    // name, fetch, mode, addr, strb, concurrent fetch, error, data from model
    add_test("m_wr_040",       1'b0, mem_pkg::machine_mode, 32'h040, 4'hf, 1'b0, 1'b0, 1'b0);
    add_test("m_wr_0c0",       1'b0, mem_pkg::machine_mode, 32'h0c0, 4'hf, 1'b0, 1'b0, 1'b0);
    add_test("m_wr_140",       1'b0, mem_pkg::machine_mode, 32'h140, 4'hf, 1'b0, 1'b0, 1'b0);
    add_test("u_wr_100",       1'b0, mem_pkg::user_mode,    32'h100, 4'hf, 1'b0, 1'b0, 1'b0);
    add_test("u_rd_100",       1'b0, mem_pkg::user_mode,    32'h100, 4'h0, 1'b0, 1'b0, 1'b1);
    add_test("u_wr_100_part",  1'b0, mem_pkg::user_mode,    32'h100, 4'h5, 1'b0, 1'b0, 1'b0);
    add_test("u_rd_100_part",  1'b0, mem_pkg::user_mode,    32'h100, 4'h0, 1'b0, 1'b0, 1'b1);
    add_test("u_fetch_040",    1'b1, mem_pkg::user_mode,    32'h040, 4'h0, 1'b0, 1'b0, 1'b1);
    add_test("u_wr_040_deny",  1'b0, mem_pkg::user_mode,    32'h040, 4'hf, 1'b0, 1'b1, 1'b0);
    add_test("m_rd_040",       1'b0, mem_pkg::machine_mode, 32'h040, 4'h0, 1'b0, 1'b0, 1'b1);
    add_test("u_fetch_100",    1'b1, mem_pkg::user_mode,    32'h100, 4'h0, 1'b0, 1'b1, 1'b0);
    add_test("u_fetch_0c0",    1'b1, mem_pkg::user_mode,    32'h0c0, 4'h0, 1'b0, 1'b0, 1'b1);
    add_test("u_wr_0c0_deny",  1'b0, mem_pkg::user_mode,    32'h0c0, 4'hf, 1'b0, 1'b1, 1'b0);
    add_test("m_rd_0c0",       1'b0, mem_pkg::machine_mode, 32'h0c0, 4'h0, 1'b0, 1'b0, 1'b1);
    add_test("u_fetch_140",    1'b1, mem_pkg::user_mode,    32'h140, 4'h0, 1'b0, 1'b1, 1'b0);
    add_test("u_rd_300_deny",  1'b0, mem_pkg::user_mode,    32'h300, 4'h0, 1'b0, 1'b1, 1'b0);
    add_test("m_wr_300",       1'b0, mem_pkg::machine_mode, 32'h300, 4'hf, 1'b0, 1'b0, 1'b0);
    add_test("m_rd_300",       1'b0, mem_pkg::machine_mode, 32'h300, 4'h0, 1'b0, 1'b0, 1'b1);
    add_test("u_rd_140_conc",  1'b0, mem_pkg::user_mode,    32'h140, 4'h0, 1'b1, 1'b0, 1'b1);
    add_test("m_fetch_300",    1'b1, mem_pkg::machine_mode, 32'h300, 4'h0, 1'b0, 1'b0, 1'b1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    clock      = 1'b0;
    reset      = 1'b0;
    imem_valid = 1'b0;
    imem_addr  = '0;
    imem_mode  = mem_pkg::user_mode;
    dmem_valid = 1'b0;
    dmem_addr  = '0;
    dmem_mode  = mem_pkg::user_mode;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    pass_count = 0;
    fail_count = 0;
    void'($urandom(32'hf3d0_aa53));
    build_table();

    for (int r = 0; r < NUM_REGIONS; r++) begin
      cfg_base[r]   = '0;
      cfg_limit[r]  = '0;
      cfg_perm[r]   = '0;
      cfg_enable[r] = 1'b0;
    end
    cfg_base[0] = 32'h000;  cfg_limit[0] = 32'h100;  cfg_perm[0] = 3'b101;  // R and X
    cfg_base[1] = 32'h100;  cfg_limit[1] = 32'h200;  cfg_perm[1] = 3'b011;  // R and W
    cfg_base[2] = 32'h0c0;  cfg_limit[2] = 32'h180;  cfg_perm[2] = 3'b000;
    cfg_enable[0] = 1'b1;
    cfg_enable[1] = 1'b1;
    cfg_enable[2] = 1'b1;

    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    for (int r = 0; r < NUM_REGIONS; r++) begin
      for (int w = 0; w < 4; w++) apb_write(8'(16 * r + 4 * w), reg_value(r, w));
    end
    check_apb();

    for (int i = 0; i < n_tests; i++) run_access(i);

    repeat (2) @(negedge clock);
    $display("Tests run: %0d, passed: %0d, failed: %0d",
             pass_count + fail_count, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
  parameter int RAM_WORDS = mem_pkg::default_ram_words
) (
  input  logic           clock,
  input  logic           reset,
  input  logic           memory_valid,
  input  mem_pkg::addr_t memory_addr,
  input  mem_pkg::data_t memory_wdata,
  input  mem_pkg::strb_t memory_wstrb,
  output mem_pkg::data_t memory_rdata,
  output logic           memory_ready
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  mem_pkg::data_t   mem [RAM_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic             waited;   // Wait state spent for the current request

  // Word index, wraps at RAM_WORDS
  assign word_idx = IDX_W'(memory_addr[31:2] % RAM_WORDS);

  always_ff @(posedge clock) begin
    if (!reset) begin
      waited       <= 1'b0;
      memory_ready <= 1'b0;
    end else begin
      memory_ready <= memory_valid && waited;   // One-shot
      waited       <= memory_valid && !waited;
    end
  end

  always_ff @(posedge clock) begin
    if (memory_valid && waited) begin
      for (int b = 0; b < 4; b++) begin
        if (memory_wstrb[b]) mem[word_idx][8*b +: 8] <= memory_wdata[8*b +: 8];
      end
      memory_rdata <= mem[word_idx];
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic           clock,
  input  logic           reset,
  input  logic           imem_valid,
  input  mem_pkg::addr_t imem_addr,
  input  mem_pkg::priv_t imem_mode,
  output logic           imem_ready,
  output logic           imem_error,
  output mem_pkg::data_t imem_rdata,
  input  logic           dmem_valid,
  input  mem_pkg::addr_t dmem_addr,
  input  mem_pkg::priv_t dmem_mode,
  input  mem_pkg::data_t dmem_wdata,
  input  mem_pkg::strb_t dmem_wstrb,
  output logic           dmem_ready,
  output logic           dmem_error,
  output mem_pkg::data_t dmem_rdata,
  output mem_pkg::addr_t chk_addr,
  output mem_pkg::priv_t chk_mode,
  output mem_pkg::perm_t chk_kind,
  input  logic           chk_fault,
  output logic           memory_valid,
  output mem_pkg::addr_t memory_addr,
  output mem_pkg::data_t memory_wdata,
  output mem_pkg::strb_t memory_wstrb,
  input  mem_pkg::data_t memory_rdata,
  input  logic           memory_ready
);

  mem_pkg::access_t state;
  logic             fault_q;   // Current access was refused by the PMP

  // Held requests, one per port
  logic             d_pend;
  mem_pkg::addr_t   d_addr;
  mem_pkg::priv_t   d_mode;
  mem_pkg::data_t   d_wdata;
  mem_pkg::strb_t   d_wstrb;
  logic             i_pend;
  mem_pkg::addr_t   i_addr;
  mem_pkg::priv_t   i_mode;

  // Access in flight on the memory bus
  mem_pkg::addr_t   cur_addr;
  mem_pkg::data_t   cur_wdata;
  mem_pkg::strb_t   cur_wstrb;

  logic             d_req;
  logic             i_req;
  logic             busy;
  logic             take_d;
  logic             take_i;
  logic             issue;
  mem_pkg::addr_t   cand_addr;
  mem_pkg::data_t   cand_wdata;
  mem_pkg::strb_t   cand_wstrb;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Selection, data before fetch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign d_req  = dmem_valid || d_pend;
  assign i_req  = imem_valid || i_pend;
  assign busy   = (state != mem_pkg::no_access) && !fault_q && !memory_ready;
  assign take_d = !busy && d_req;
  assign take_i = !busy && !d_req && i_req;
  assign issue  = take_d || take_i;

  always_comb begin
    if (d_req) begin
      cand_addr  = dmem_valid ? dmem_addr : d_addr;
      chk_mode   = dmem_valid ? dmem_mode : d_mode;
      cand_wdata = dmem_valid ? dmem_wdata : d_wdata;
      cand_wstrb = dmem_valid ? dmem_wstrb : d_wstrb;
      chk_kind   = (cand_wstrb != '0) ? 3'b010 : 3'b001; // Write or read
    end else begin
      cand_addr  = imem_valid ? imem_addr : i_addr;
      chk_mode   = imem_valid ? imem_mode : i_mode;
      cand_wdata = '0;
      cand_wstrb = '0;
      chk_kind   = 3'b100; // Execute
    end
  end

  assign chk_addr     = cand_addr;
  assign memory_valid = busy || (issue && !chk_fault);
  assign memory_addr  = busy ? cur_addr : cand_addr;
  assign memory_wdata = busy ? cur_wdata : cand_wdata;
  assign memory_wstrb = busy ? cur_wstrb : cand_wstrb;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state   <= mem_pkg::no_access;
      fault_q <= 1'b0;
      d_pend  <= 1'b0;
      i_pend  <= 1'b0;
    end else begin
      if (dmem_valid) d_pend <= 1'b1;
      if (imem_valid) i_pend <= 1'b1;
      if (take_d) d_pend <= 1'b0;   // Taken straight away
      if (take_i) i_pend <= 1'b0;
      if (issue) begin
        state   <= take_d ? mem_pkg::data_access : mem_pkg::instr_access;
        fault_q <= chk_fault;
      end else if (!busy) begin
        state   <= mem_pkg::no_access;
        fault_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (dmem_valid) begin
      d_addr  <= dmem_addr;
      d_mode  <= dmem_mode;
      d_wdata <= dmem_wdata;
      d_wstrb <= dmem_wstrb;
    end
    if (imem_valid) begin
      i_addr <= imem_addr;
      i_mode <= imem_mode;
    end
    if (issue) begin
      cur_addr  <= cand_addr;
      cur_wdata <= cand_wdata;
      cur_wstrb <= cand_wstrb;
    end
  end

  // Responses go to the owner of the current access
  assign imem_ready = (state == mem_pkg::instr_access) && (fault_q || memory_ready);
  assign imem_error = (state == mem_pkg::instr_access) && fault_q;
  assign imem_rdata = (state == mem_pkg::instr_access && !fault_q && memory_ready) ?
                      memory_rdata : '0;
  assign dmem_ready = (state == mem_pkg::data_access) && (fault_q || memory_ready);
  assign dmem_error = (state == mem_pkg::data_access) && fault_q;
  assign dmem_rdata = (state == mem_pkg::data_access && !fault_q && memory_ready) ?
                      memory_rdata : '0;

  // Bus request held unchanged until the RAM answers
  assert property (@(posedge clock) disable iff (!reset)
    memory_valid && !memory_ready |=> memory_ready ||
    (memory_valid && $stable(memory_addr) && $stable(memory_wdata) &&
     $stable(memory_wstrb)));

  // The RAM answers only an access that was issued to it
  assert property (@(posedge clock) disable iff (!reset)
    memory_ready |-> (state != mem_pkg::no_access) && !fault_q);

endmodule

`default_nettype wire

//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [31:0] addr_t;     // Byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;     // All zero is a read
  typedef logic [7:0]  apb_addr_t; // PMP register offset

  // Bit 0 read, bit 1 write, bit 2 execute
  typedef logic [2:0] perm_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Enumerations
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    user_mode    = 2'd0,
    machine_mode = 2'd3
  } priv_t;

  // Arbiter ownership of the memory bus
  typedef enum logic [1:0] {
    no_access    = 2'd0,
    instr_access = 2'd1,
    data_access  = 2'd2
  } access_t;

  // Top-level defaults
  localparam int default_num_regions = 4;
  localparam int default_ram_words   = 256;

endpackage

`default_nettype wire

//--- verilog/mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys #(
  parameter int NUM_REGIONS = mem_pkg::default_num_regions,
  parameter int RAM_WORDS   = mem_pkg::default_ram_words
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               imem_valid,
  input  mem_pkg::addr_t     imem_addr,
  input  mem_pkg::priv_t     imem_mode,
  output logic               imem_ready,
  output logic               imem_error,
  output mem_pkg::data_t     imem_rdata,
  input  logic               dmem_valid,
  input  mem_pkg::addr_t     dmem_addr,
  input  mem_pkg::priv_t     dmem_mode,
  input  mem_pkg::data_t     dmem_wdata,
  input  mem_pkg::strb_t     dmem_wstrb,
  output logic               dmem_ready,
  output logic               dmem_error,
  output mem_pkg::data_t     dmem_rdata,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  mem_pkg::apb_addr_t paddr,
  input  mem_pkg::data_t     pwdata,
  output mem_pkg::data_t     prdata,
  output logic               pready,
  output logic               pslverr
);

  mem_pkg::addr_t chk_addr;
  mem_pkg::priv_t chk_mode;
  mem_pkg::perm_t chk_kind;
  logic           chk_fault;

  logic           memory_valid;
  mem_pkg::addr_t memory_addr;
  mem_pkg::data_t memory_wdata;
  mem_pkg::strb_t memory_wstrb;
  mem_pkg::data_t memory_rdata;
  logic           memory_ready;

  logic [NUM_REGIONS*32-1:0] region_base;
  logic [NUM_REGIONS*32-1:0] region_limit;
  logic [NUM_REGIONS*3-1:0]  region_perm;
  logic [NUM_REGIONS-1:0]    region_enable;
  logic [NUM_REGIONS-1:0]    region_hit;
  logic [NUM_REGIONS-1:0]    region_grant;

  mem_arbiter u_arbiter (
    .clock        (clock),
    .reset        (reset),
    .imem_valid   (imem_valid),
    .imem_addr    (imem_addr),
    .imem_mode    (imem_mode),
    .imem_ready   (imem_ready),
    .imem_error   (imem_error),
    .imem_rdata   (imem_rdata),
    .dmem_valid   (dmem_valid),
    .dmem_addr    (dmem_addr),
    .dmem_mode    (dmem_mode),
    .dmem_wdata   (dmem_wdata),
    .dmem_wstrb   (dmem_wstrb),
    .dmem_ready   (dmem_ready),
    .dmem_error   (dmem_error),
    .dmem_rdata   (dmem_rdata),
    .chk_addr     (chk_addr),
    .chk_mode     (chk_mode),
    .chk_kind     (chk_kind),
    .chk_fault    (chk_fault),
    .memory_valid (memory_valid),
    .memory_addr  (memory_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .memory_rdata (memory_rdata),
    .memory_ready (memory_ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // PMP
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  pmp_csr_apb #(
    .NUM_REGIONS (NUM_REGIONS)
  ) u_pmp_csr (
    .clock         (clock),
    .reset         (reset),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .region_base   (region_base),
    .region_limit  (region_limit),
    .region_perm   (region_perm),
    .region_enable (region_enable)
  );

  for (genvar g = 0; g < NUM_REGIONS; g++) begin : g_region
    pmp_region u_region (
      .base     (region_base[g*32 +: 32]),
      .limit    (region_limit[g*32 +: 32]),
      .perm     (region_perm[g*3 +: 3]),
      .enable   (region_enable[g]),
      .chk_addr (chk_addr),
      .chk_kind (chk_kind),
      .hit      (region_hit[g]),
      .grant    (region_grant[g])
    );
  end

  pmp_resolve #(
    .NUM_REGIONS (NUM_REGIONS)
  ) u_pmp_resolve (
    .hit       (region_hit),
    .grant     (region_grant),
    .chk_mode  (chk_mode),
    .chk_fault (chk_fault)
  );

  data_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_data_ram (
    .clock        (clock),
    .reset        (reset),
    .memory_valid (memory_valid),
    .memory_addr  (memory_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .memory_rdata (memory_rdata),
    .memory_ready (memory_ready)
  );

endmodule

`default_nettype wire

//--- verilog/pmp_csr_apb.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_csr_apb #(
  parameter int NUM_REGIONS = mem_pkg::default_num_regions
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  mem_pkg::apb_addr_t       paddr,
  input  mem_pkg::data_t           pwdata,
  output mem_pkg::data_t           prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic [NUM_REGIONS*32-1:0] region_base,
  output logic [NUM_REGIONS*32-1:0] region_limit,
  output logic [NUM_REGIONS*3-1:0]  region_perm,
  output logic [NUM_REGIONS-1:0]    region_enable
);

  mem_pkg::addr_t         base_q  [NUM_REGIONS];
  mem_pkg::addr_t         limit_q [NUM_REGIONS];
  mem_pkg::perm_t         perm_q  [NUM_REGIONS];
  logic [NUM_REGIONS-1:0] enable_q;

  logic [3:0] reg_idx;   // 16 bytes per region
  logic [1:0] reg_word;
  logic       in_range;
  logic       wr_en;

  assign reg_idx  = paddr[7:4];
  assign reg_word = paddr[3:2];
  assign in_range = reg_idx < NUM_REGIONS;
  assign wr_en    = psel && penable && pwrite && in_range;
  assign pready   = 1'b1;   // Zero wait states
  assign pslverr  = psel && penable && !in_range;

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        base_q[i]  <= '0;
        limit_q[i] <= '0;
        perm_q[i]  <= '0;
      end
      enable_q <= '0;
    end else if (wr_en) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (reg_idx == i) begin
          case (reg_word)
            2'd0:    base_q[i]   <= pwdata;
            2'd1:    limit_q[i]  <= pwdata;
            2'd2:    perm_q[i]   <= pwdata[2:0];
            default: enable_q[i] <= pwdata[0];
          endcase
        end
      end
    end
  end

  // Readback
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (reg_idx == i) begin
          case (reg_word)
            2'd0:    prdata = base_q[i];
            2'd1:    prdata = limit_q[i];
            2'd2:    prdata = {29'd0, perm_q[i]};
            default: prdata = {31'd0, enable_q[i]};
          endcase
        end
      end
    end
  end

  for (genvar g = 0; g < NUM_REGIONS; g++) begin : g_flat
    assign region_base[g*32 +: 32] = base_q[g];
    assign region_limit[g*32 +: 32] = limit_q[g];
    assign region_perm[g*3 +: 3] = perm_q[g];
  end
  assign region_enable = enable_q;

  assert property (@(posedge clock) disable iff (!reset) penable |-> psel);

endmodule

`default_nettype wire

//--- verilog/pmp_region.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_region (
  input  mem_pkg::addr_t base,
  input  mem_pkg::addr_t limit,
  input  mem_pkg::perm_t perm,
  input  logic           enable,
  input  mem_pkg::addr_t chk_addr,
  input  mem_pkg::perm_t chk_kind,
  output logic           hit,
  output logic           grant
);

  logic above_base;
  logic below_limit;

  // Top-of-range pair, limit is exclusive
  assign above_base  = chk_addr >= base;
  assign below_limit = chk_addr < limit;
  assign hit         = enable && above_base && below_limit;

  // chk_kind carries a single bit
  assign grant = |(perm & chk_kind);

endmodule

`default_nettype wire

//--- verilog/pmp_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_resolve #(
  parameter int NUM_REGIONS = mem_pkg::default_num_regions
) (
  input  logic [NUM_REGIONS-1:0] hit,
  input  logic [NUM_REGIONS-1:0] grant,
  input  mem_pkg::priv_t         chk_mode,
  output logic                   chk_fault
);

  logic found;
  logic first_grant;

  // Lowest index wins
  always_comb begin
    found       = 1'b0;
    first_grant = 1'b0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (hit[i] && !found) begin
        found       = 1'b1;
        first_grant = grant[i];
      end
    end
  end

  // Machine mode bypasses protection
  assign chk_fault = (chk_mode != mem_pkg::machine_mode) && (!found || !first_grant);

endmodule

`default_nettype wire
